// File: hdl/wideAdd_macros.svh
`ifndef WIDEADD_MACROS_SVH
`define WIDEADD_MACROS_SVH

// chunk geometry, chunk width is also the bus data width
`define WA_CHUNK_W 16
`define WA_NUM_CHUNKS 8
`define WA_ADR_W 5

// word address map
`define WA_ADR_A 0
`define WA_ADR_B 8
`define WA_ADR_RES 16
`define WA_ADR_CTRL 24

`define WA_SPEED 2 // 0 serial, 1 brent-kung, 2 sklansky

`endif

// File: hdl/wideAddPkg.sv
`include "wideAdd_macros.svh"

package wideAddPkg;

	typedef logic [`WA_CHUNK_W-1:0] chunkT;
	typedef logic [$clog2(`WA_NUM_CHUNKS)-1:0] chunkIdxT;
	typedef logic [`WA_ADR_W-1:0] wbAdrT;

	// master to slave, classic cycle
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wbAdrT adr;
		chunkT dat;
	} wbReqT;

	typedef struct packed {
		logic ack;
		chunkT dat;
	} wbRspT;

	typedef struct packed {
		logic sub; // add inverted b
		logic cin;
	} addCmdT;

	typedef enum logic [1:0] {seqIdle, seqRun, seqDone} seqStateT;

endpackage

// File: hdl/prefixAndOr.sv
`timescale 1ns/10ps

module prefixAndOr #(
	parameter int width = 8,
	parameter int speed = 0 // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] gi,
	input  logic [width-1:0] pi,
	output logic [width-1:0] go,
	output logic [width-1:0] po
);

	localparam int n = width;
	localparam int m = $clog2(width);

	if (speed == 0) begin : gSerial
		logic [n-1:0] gt, pt;

		assign gt[0] = gi[0];
		assign pt[0] = pi[0];
		for (genvar i = 1; i < n; i++) begin : gBit
			assign gt[i] = gi[i] | (pi[i] & gt[i-1]);
			assign pt[i] = pi[i] & pt[i-1];
		end
		assign go = gt;
		assign po = pt;
	end else if (speed == 1) begin : gBrentKung
		logic [2*m-1:0][n-1:0] gt, pt; // stage 0 is the input

		assign gt[0] = gi;
		assign pt[0] = pi;
		// up-sweep, group ends at 2**l - 1
		for (genvar l = 1; l <= m; l++) begin : gUp
			for (genvar j = 0; j < n; j++) begin : gBit
				if ((j + 1) % (2 ** l) == 0) begin : gBlack
					assign gt[l][j] = gt[l-1][j] | (pt[l-1][j] & gt[l-1][j - 2**(l-1)]);
					assign pt[l][j] = pt[l-1][j] & pt[l-1][j - 2**(l-1)];
				end else begin : gWhite
					assign gt[l][j] = gt[l-1][j];
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end
		// down-sweep fills the positions in between
		for (genvar s = m + 1; s < 2 * m; s++) begin : gDown
			localparam int d = 2 * m - s;
			for (genvar j = 0; j < n; j++) begin : gBit
				if (((j + 1) % (2 ** d) == 2 ** (d - 1)) && (j >= 2 ** d)) begin : gBlack
					assign gt[s][j] = gt[s-1][j] | (pt[s-1][j] & gt[s-1][j - 2**(d-1)]);
					assign pt[s][j] = pt[s-1][j] & pt[s-1][j - 2**(d-1)];
				end else begin : gWhite
					assign gt[s][j] = gt[s-1][j];
					assign pt[s][j] = pt[s-1][j];
				end
			end
		end
		assign go = gt[2*m-1];
		assign po = pt[2*m-1];
	end else begin : gSklansky
		logic [m:0][n-1:0] gt, pt;

		assign gt[0] = gi;
		assign pt[0] = pi;
		for (genvar l = 1; l <= m; l++) begin : gLevel
			for (genvar j = 0; j < n; j++) begin : gBit
				// upper half of each block takes the top of the lower half
				if (((j >> (l - 1)) % 2) == 1) begin : gBlack
					localparam int src = ((j >> (l - 1)) << (l - 1)) - 1;
					assign gt[l][j] = gt[l-1][j] | (pt[l-1][j] & gt[l-1][src]);
					assign pt[l][j] = pt[l-1][j] & pt[l-1][src];
				end else begin : gWhite
					assign gt[l][j] = gt[l-1][j];
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end
		assign go = gt[m];
		assign po = pt[m];
	end

endmodule

module prefixAndOrCfast #(
	parameter int width = 8,
	parameter int speed = 0
) (
	input  logic [width-1:0] gi,
	input  logic [width-1:0] pi,
	input  logic             ci,
	output logic [width-1:0] go,
	output logic [width-1:0] po
);

	logic [width-1:0] gt, pt;

	prefixAndOr #(
		.width(width),
		.speed(speed)
	) prefixAndOr_i (
		.gi(gi),
		.pi(pi),
		.go(gt),
		.po(pt)
	);

	// one extra and-or level, carry-in lands on every group
	assign go = gt | (pt & {width{ci}});
	assign po = pt;

endmodule

// File: hdl/chunkAdder.sv
`timescale 1ns/10ps
`include "wideAdd_macros.svh"

module chunkAdder (
	input  wideAddPkg::chunkT a,
	input  wideAddPkg::chunkT b,
	input  logic              sub,
	input  logic              ci,
	output wideAddPkg::chunkT sum,
	output logic              co
);

	import wideAddPkg::*;

	chunkT bx; // b or its complement
	chunkT g, p;
	chunkT gg; // group generate incl. carry-in

	assign bx = sub ? ~b : b;
	assign g = a & bx;
	assign p = a ^ bx;

	prefixAndOrCfast #(
		.width(`WA_CHUNK_W),
		.speed(`WA_SPEED)
	) prefixAndOrCfast_i (
		.gi(g),
		.pi(p),
		.ci(ci),
		.go(gg),
		.po()
	);

	// carry into bit i is the group generate of bits below it
	assign sum = p ^ {gg[`WA_CHUNK_W-2:0], ci};
	assign co = gg[`WA_CHUNK_W-1];

endmodule

// File: hdl/operandStore.sv
`timescale 1ns/10ps
`include "wideAdd_macros.svh"

module operandStore (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 hostWr,
	input  wideAddPkg::wbAdrT    hostAdr,
	input  wideAddPkg::chunkT    hostDat,
	output wideAddPkg::chunkT    hostRd,
	input  wideAddPkg::chunkIdxT idx,
	output wideAddPkg::chunkT    aChunk,
	output wideAddPkg::chunkT    bChunk,
	input  logic                 resWr,
	input  wideAddPkg::chunkT    resDat
);

	import wideAddPkg::*;

	chunkT aReg[`WA_NUM_CHUNKS];
	chunkT bReg[`WA_NUM_CHUNKS];
	chunkT resReg[`WA_NUM_CHUNKS];
	logic inA, inB, inRes;
	chunkIdxT hostIdx;

	assign inA = (hostAdr >= `WA_ADR_A) && (hostAdr < `WA_ADR_A + `WA_NUM_CHUNKS);
	assign inB = (hostAdr >= `WA_ADR_B) && (hostAdr < `WA_ADR_B + `WA_NUM_CHUNKS);
	assign inRes = (hostAdr >= `WA_ADR_RES) && (hostAdr < `WA_ADR_RES + `WA_NUM_CHUNKS);
	assign hostIdx = hostAdr[$bits(chunkIdxT)-1:0]; // bases aligned to chunk count

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `WA_NUM_CHUNKS; i++) begin
				aReg[i] <= '0;
				bReg[i] <= '0;
				resReg[i] <= '0;
			end
		end else begin
			if (hostWr && inA)
				aReg[hostIdx] <= hostDat;
			if (hostWr && inB)
				bReg[hostIdx] <= hostDat;
			if (resWr)
				resReg[idx] <= resDat; // result is host read-only
		end
	end

	always_comb begin
		hostRd = '0; // unmapped reads give 0
		if (inA)
			hostRd = aReg[hostIdx];
		else if (inB)
			hostRd = bReg[hostIdx];
		else if (inRes)
			hostRd = resReg[hostIdx];
	end

	assign aChunk = aReg[idx];
	assign bChunk = bReg[idx];

endmodule

// File: hdl/chunkCounter.sv
`timescale 1ns/10ps
`include "wideAdd_macros.svh"

module chunkCounter (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 clear,
	input  logic                 step,
	output wideAddPkg::chunkIdxT idx,
	output logic                 last
);

	import wideAddPkg::*;

	chunkIdxT cnt;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			cnt <= '0;
		else if (clear)
			cnt <= '0;
		else if (step)
			cnt <= cnt + chunkIdxT'(1); // wraps after the top chunk
	end

	assign idx = cnt;
	assign last = cnt == chunkIdxT'(`WA_NUM_CHUNKS - 1);

endmodule

// File: hdl/addSequencer.sv
`timescale 1ns/10ps

module addSequencer (
	input  logic               clk,
	input  logic               arstN,
	input  logic               start,
	input  wideAddPkg::addCmdT cmd,
	input  logic               last,
	input  logic               co,
	output logic               clear,
	output logic               step,
	output logic               carry,
	output logic               sub,
	output logic               resWr,
	output logic               busy,
	output logic               done,
	output logic               carryOut
);

	import wideAddPkg::*;

	seqStateT state;
	logic carryQ; // carry between chunks
	logic subQ;
	logic coQ;
	logic running;

	assign running = state == seqRun;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= seqIdle;
			carryQ <= 1'b0;
			subQ <= 1'b0;
			coQ <= 1'b0;
		end else begin
			case (state)
				seqIdle, seqDone: begin
					if (start) begin
						state <= seqRun;
						carryQ <= cmd.cin;
						subQ <= cmd.sub;
					end
				end
				seqRun: begin
					carryQ <= co;
					if (last) begin
						state <= seqDone;
						coQ <= co; // top chunk carry is the result carry
					end
				end
				default: state <= seqIdle;
			endcase
		end
	end

	assign clear = start & ~running; // counter back to chunk 0
	assign step = running;
	assign resWr = running;
	assign carry = carryQ;
	assign sub = subQ;
	assign busy = running;
	assign done = state == seqDone;
	assign carryOut = coQ;

endmodule

// File: hdl/wbRegIf.sv
`timescale 1ns/10ps
`include "wideAdd_macros.svh"

module wbRegIf (
	input  logic               clk,
	input  logic               arstN,
	input  wideAddPkg::wbReqT  wbReq,
	output wideAddPkg::wbRspT  wbRsp,
	input  logic               busy,
	input  logic               done,
	input  logic               carryOut,
	output logic               hostWr,
	output wideAddPkg::wbAdrT  hostAdr,
	output wideAddPkg::chunkT  hostDat,
	input  wideAddPkg::chunkT  hostRd,
	output logic               start,
	output wideAddPkg::addCmdT cmd
);

	import wideAddPkg::*;

	logic ackQ;
	chunkT datQ;
	logic access; // new request, not yet acked
	logic wrCycle; // write held during its ack cycle
	logic ctrlSel;
	chunkT status;
	chunkT rdMux;

	assign access = wbReq.cyc & wbReq.stb & ~ackQ;
	assign wrCycle = ackQ & wbReq.cyc & wbReq.stb & wbReq.we;
	assign ctrlSel = wbReq.adr == wbAdrT'(`WA_ADR_CTRL);

	// operands frozen while an addition runs
	assign hostWr = wrCycle & ~ctrlSel & ~busy;
	assign hostAdr = wbReq.adr;
	assign hostDat = wbReq.dat;

	// control word: bit 0 start, bit 1 cin, bit 2 sub
	assign start = wrCycle & ctrlSel & wbReq.dat[0] & ~busy;
	assign cmd = '{sub: wbReq.dat[2], cin: wbReq.dat[1]};

	assign status = {{(`WA_CHUNK_W-3){1'b0}}, carryOut, done, busy};
	assign rdMux = ctrlSel ? status : hostRd;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			ackQ <= 1'b0;
		else
			ackQ <= access; // single cycle, master drops stb
	end

	always_ff @(posedge clk) begin
		if (access)
			datQ <= rdMux;
	end

	assign wbRsp = '{ack: ackQ, dat: datQ};

endmodule

// File: hdl/wideAddTop.sv
`timescale 1ns/10ps

module wideAddTop (
	input  logic              clk,
	input  logic              arstN,
	input  wideAddPkg::wbReqT wbReq,
	output wideAddPkg::wbRspT wbRsp
);

	import wideAddPkg::*;

	logic hostWr;
	wbAdrT hostAdr;
	chunkT hostDat, hostRd;
	logic start;
	addCmdT cmd;
	logic busy, done, carryOut;
	logic clear, step, last;
	chunkIdxT idx;
	chunkT aChunk, bChunk, sum;
	logic carry, sub, co, resWr;

	wbRegIf wbRegIf_i (
		.clk(clk),
		.arstN(arstN),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.busy(busy),
		.done(done),
		.carryOut(carryOut),
		.hostWr(hostWr),
		.hostAdr(hostAdr),
		.hostDat(hostDat),
		.hostRd(hostRd),
		.start(start),
		.cmd(cmd)
	);

	operandStore operandStore_i (
		.clk(clk),
		.arstN(arstN),
		.hostWr(hostWr),
		.hostAdr(hostAdr),
		.hostDat(hostDat),
		.hostRd(hostRd),
		.idx(idx),
		.aChunk(aChunk),
		.bChunk(bChunk),
		.resWr(resWr),
		.resDat(sum)
	);

	chunkCounter chunkCounter_i (
		.clk(clk),
		.arstN(arstN),
		.clear(clear),
		.step(step),
		.idx(idx),
		.last(last)
	);

	addSequencer addSequencer_i (
		.clk(clk),
		.arstN(arstN),
		.start(start),
		.cmd(cmd),
		.last(last),
		.co(co),
		.clear(clear),
		.step(step),
		.carry(carry),
		.sub(sub),
		.resWr(resWr),
		.busy(busy),
		.done(done),
		.carryOut(carryOut)
	);

	chunkAdder chunkAdder_i (
		.a(aChunk),
		.b(bChunk),
		.sub(sub),
		.ci(carry),
		.sum(sum),
		.co(co)
	);

endmodule

// File: dv/wideAdd_asserts.sv
`timescale 1ns/10ps
`include "wideAdd_macros.svh"

module wideAddAsserts (
	input logic              clk,
	input logic              arstN,
	input wideAddPkg::wbReqT wbReq,
	input wideAddPkg::wbRspT wbRsp,
	input logic              busy,
	input logic              done
);

	import wideAddPkg::*;

	int failCount = 0;

	ackSingle: assert property (@(posedge clk) disable iff (!arstN)
		wbRsp.ack |=> !wbRsp.ack)
	else begin
		failCount++;
		$error("ack high for two consecutive cycles");
	end

	ackAfterStb: assert property (@(posedge clk) disable iff (!arstN)
		wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb))
	else begin
		failCount++;
		$error("ack without a preceding strobe");
	end

	// one chunk per busy cycle
	busyLength: assert property (@(posedge clk) disable iff (!arstN)
		$rose(busy) |-> busy [* `WA_NUM_CHUNKS] ##1 !busy)
	else begin
		failCount++;
		$error("busy length differs from the chunk count");
	end

	busyDoneExcl: assert property (@(posedge clk) disable iff (!arstN)
		!(busy && done))
	else begin
		failCount++;
		$error("busy and done high together");
	end

endmodule

bind wideAddTop wideAddAsserts wideAddAsserts_i (
	.clk(clk),
	.arstN(arstN),
	.wbReq(wbReq),
	.wbRsp(wbRsp),
	.busy(busy),
	.done(done)
);

// File: dv/wideAddTb.sv
`timescale 1ns/10ps
`include "wideAdd_macros.svh"

module wideAddTb;

	import wideAddPkg::*;

	localparam int opW = `WA_CHUNK_W * `WA_NUM_CHUNKS;
	localparam int timeoutCycles = 20000; // ~40 tests of ~60 accesses, with margin

	logic clk;
	logic arstN;
	wbReqT wbReq;
	wbRspT wbRsp;

	int errCount = 0;
	int testPass = 0;
	int testFail = 0;
	int cycleCount = 0;

	wideAddTop wideAddTop_i (
		.clk(clk),
		.arstN(arstN),
		.wbReq(wbReq),
		.wbRsp(wbRsp)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycleCount);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic checkVal(input string name, input logic [opW:0] expV,
			input logic [opW:0] actV);
		if (expV !== actV) begin
			$display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, expV, actV);
			errCount++;
		end
	endtask

	task automatic finishTest(input string name, input int errBefore);
		if (errCount == errBefore) begin
			testPass++;
			$display("test %s passed", name);
		end else begin
			testFail++;
			$display("test %s failed", name);
		end
	endtask

	// called at edge + 1, returns at edge + 1
	task automatic busCycle(input logic we, input wbAdrT adr, input chunkT datIn,
			output chunkT datOut);
		wbReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: datIn};
		do begin
			@(posedge clk);
			#1;
		end while (!wbRsp.ack);
		datOut = wbRsp.dat;
		@(posedge clk); // write lands at the end of the ack cycle
		#1;
		wbReq = '0;
	endtask

	task automatic wbWrite(input wbAdrT adr, input chunkT dat);
		chunkT unused;
		busCycle(1'b1, adr, dat, unused);
	endtask

	task automatic wbRead(input wbAdrT adr, output chunkT dat);
		busCycle(1'b0, adr, '0, dat);
	endtask

	task automatic pollDone(output chunkT status);
		do
			wbRead(wbAdrT'(`WA_ADR_CTRL), status);
		while (!status[1]);
	endtask

	task automatic writeOperands(input logic [opW-1:0] a, input logic [opW-1:0] b);
		for (int i = 0; i < `WA_NUM_CHUNKS; i++) begin
			wbWrite(wbAdrT'(`WA_ADR_A + i), a[i*`WA_CHUNK_W +: `WA_CHUNK_W]);
			wbWrite(wbAdrT'(`WA_ADR_B + i), b[i*`WA_CHUNK_W +: `WA_CHUNK_W]);
		end
	endtask

	task automatic readChunks(input int base, output logic [opW-1:0] val);
		chunkT c;
		for (int i = 0; i < `WA_NUM_CHUNKS; i++) begin
			wbRead(wbAdrT'(base + i), c);
			val[i*`WA_CHUNK_W +: `WA_CHUNK_W] = c;
		end
	endtask

	task automatic runAdd(input logic [opW-1:0] a, input logic [opW-1:0] b, input logic sub,
			input logic cin, output logic [opW-1:0] res, output logic co);
		chunkT status;
		writeOperands(a, b);
		wbWrite(wbAdrT'(`WA_ADR_CTRL), {13'd0, sub, cin, 1'b1});
		pollDone(status);
		readChunks(`WA_ADR_RES, res);
		co = status[2];
	endtask

	// A + (sub ? ~B : B) + cin on 129 bits
	function automatic logic [opW:0] refSum(input logic [opW-1:0] a, input logic [opW-1:0] b,
			input logic sub, input logic cin);
		logic [opW-1:0] bx;
		logic [opW:0] s;
		bx = sub ? ~b : b;
		s = {1'b0, a} + {1'b0, bx};
		s = s + cin;
		return s;
	endfunction

	task automatic runVectors();
		int fd;
		int n;
		int lineNo;
		int errBefore;
		string line;
		logic [opW-1:0] a, b, expRes, res;
		logic sub, cin, expCo, co;
		fd = $fopen("dv/wideAdd_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file dv/wideAdd_vectors.txt");
			errCount++;
			testFail++;
			return;
		end
		lineNo = 0;
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			lineNo++;
			if (n <= 0 || line.len() < 2 || line[0] == "#")
				continue; // blank or column notes
			n = $sscanf(line, "%h %h %h %h %h %h", a, b, sub, cin, expRes, expCo);
			if (n != 6) begin
				$display("vector file line %0d is not in the expected format", lineNo);
				errCount++;
				testFail++;
				continue;
			end
			errBefore = errCount;
			runAdd(a, b, sub, cin, res, co);
			checkVal("result", expRes, res);
			checkVal("carryOut", expCo, co);
			if (sub && cin)
				checkVal("carryOut (A >= B)", a >= b, co);
			finishTest($sformatf("vector line %0d", lineNo), errBefore);
		end
		$fclose(fd);
	endtask

	task automatic busyTest();
		logic [opW-1:0] a, b, res, aBack;
		logic [opW:0] expV;
		chunkT status;
		int errBefore;
		errBefore = errCount;
		a = {4{32'h89abcdef}};
		b = {4{32'h76543211}};
		writeOperands(a, b);
		wbWrite(wbAdrT'(`WA_ADR_CTRL), 16'h0001);
		wbRead(wbAdrT'(`WA_ADR_CTRL), status);
		checkVal("status.busy", 1'b1, status[0]);
		wbWrite(wbAdrT'(`WA_ADR_CTRL), 16'h0003); // second start, cin set
		wbWrite(wbAdrT'(`WA_ADR_A), 16'h5555);
		pollDone(status);
		checkVal("status.busy after done", 1'b0, status[0]);
		readChunks(`WA_ADR_RES, res);
		expV = refSum(a, b, 1'b0, 1'b0);
		checkVal("result", expV[opW-1:0], res);
		checkVal("carryOut", expV[opW], status[2]);
		readChunks(`WA_ADR_A, aBack);
		checkVal("A readback", a, aBack);
		finishTest("writes while busy", errBefore);
	endtask

	initial begin
		chunkT status;
		logic [opW-1:0] a, b, res;
		logic [opW:0] expV;
		logic sub, cin, co;
		int errBefore;
		clk = 1'b0;
		arstN = 1'b0;
		wbReq = '0;
		void'($urandom(83));
		repeat (8) @(posedge clk);
		#1;
		arstN = 1'b1;

		errBefore = errCount;
		wbRead(wbAdrT'(`WA_ADR_CTRL), status);
		checkVal("status", '0, status);
		readChunks(`WA_ADR_RES, res);
		checkVal("result after reset", '0, res);
		finishTest("reset state", errBefore);

		runVectors();
		busyTest();

		for (int t = 0; t < 20; t++) begin
			for (int i = 0; i < opW / 32; i++) begin
				a[i*32 +: 32] = $urandom;
				b[i*32 +: 32] = $urandom;
			end
			sub = $urandom_range(1);
			cin = $urandom_range(1);
			errBefore = errCount;
			runAdd(a, b, sub, cin, res, co);
			expV = refSum(a, b, sub, cin);
			checkVal("result", expV[opW-1:0], res);
			checkVal("carryOut", expV[opW], co);
			finishTest($sformatf("random %0d (sub %0b cin %0b)", t, sub, cin), errBefore);
		end

		$display("tests passed %0d, failed %0d, checks failed %0d, assertions failed %0d",
			testPass, testFail, errCount, wideAddTop_i.wideAddAsserts_i.failCount);
		if (testFail == 0 && errCount == 0 && wideAddTop_i.wideAddAsserts_i.failCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: dv/wideAdd_vectors.txt
# columns: A B sub cin result carryOut, all hex, 128-bit operands
# result = A + (sub ? ~B : B) + cin mod 2^128, carryOut is bit 128
0 0 0 0 0 0
1 1 0 0 2 0
1 1 0 1 3 0
ffffffffffffffffffffffffffffffff 0 0 1 0 1
ffff 1 0 0 10000 0
ffffffffffffffffffffffffffffffff 1 0 0 0 1
80000000000000000000000000000000 80000000000000000000000000000000 0 0 0 1
0123456789abcdef0123456789abcdef fedcba9876543210fedcba9876543210 0 0 ffffffffffffffffffffffffffffffff 0
0123456789abcdef0123456789abcdef fedcba9876543210fedcba9876543210 0 1 0 1
0000ffff0000ffff0000ffff0000ffff 00000001000000010000000100000001 0 0 00010000000100000001000000010000 0
5 3 1 1 2 1
3 5 1 1 fffffffffffffffffffffffffffffffe 0
0123456789abcdef0123456789abcdef 0123456789abcdef0123456789abcdef 1 1 0 1
0 1 1 1 ffffffffffffffffffffffffffffffff 0
10000 1 1 1 ffff 1
5 3 1 0 1 1

// File: verilog.f
+incdir+hdl
hdl/wideAddPkg.sv
hdl/prefixAndOr.sv
hdl/chunkAdder.sv
hdl/operandStore.sv
hdl/chunkCounter.sv
hdl/addSequencer.sv
hdl/wbRegIf.sv
hdl/wideAddTop.sv
dv/wideAdd_asserts.sv
dv/wideAddTb.sv

// File: Bender.yml
package:
  name: wide_add

sources:
  - target: any(rtl, test)
    include_dirs:
      - hdl
    files:
      - hdl/wideAddPkg.sv
      - hdl/prefixAndOr.sv
      - hdl/chunkAdder.sv
      - hdl/operandStore.sv
      - hdl/chunkCounter.sv
      - hdl/addSequencer.sv
      - hdl/wbRegIf.sv
      - hdl/wideAddTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/wideAdd_asserts.sv
      - dv/wideAddTb.sv
